/* cpuOpcodesPkg.sv */
// CPU instruction encodings
package cpuOpcodesPkg;

	// Instruction byte fields
	localparam int OpcodeWidth = 5;   // OpcodeCondIn[7:3]
	localparam int BranchWidth = 3;   // OpcodeCondIn[2:0]

	// Status register layout
	localparam int FlagWidth = 4;
	localparam int FlagZ = 0;   // Zero
	localparam int FlagC = 1;   // Carry
	localparam int FlagV = 2;   // Overflow
	localparam int FlagN = 3;   // Negative

	typedef enum logic [OpcodeWidth-1:0] {
		ADD,
		ADDI,
		ADDIB,
		ADC,
		ADCI,
		SUB,
		SUBI,
		SUBIB,
		SUC,
		SUCI,
		NEG,
		CMP,
		CMPI,
		AND,
		OR,
		XOR,
		NAND,
		NOR,
		NOT,
		LSL,
		LSR,
		ASR,
		LUI,   // Load upper immediate
		LLI,   // Load lower immediate
		LDW,
		STW,
		BRANCH,   // Condition in low bits
		INTCTL    // Interrupt control group
	} opcode_t;

	// Branch conditions, low three bits of the instruction byte
	typedef enum logic [BranchWidth-1:0] {
		BR,
		BNE,
		BE,
		BLT,
		BGE,
		BWL,   // Branch with link
		RET,
		JMP
	} branch_t;

	// Interrupt control codes reuse the condition field
	localparam branch_t IntEnableCode = branch_t'(3'd1);
	localparam branch_t IntDisableCode = branch_t'(3'd2);

endpackage

/* cpuControlPkg.sv */
// Control unit sequencing and select types
package cpuControlPkg;

	// Major state
	typedef enum logic [1:0] {
		Fetch,
		Execute,
		Interrupt
	} state_t;

	typedef enum logic [2:0] {
		Cycle0,
		Cycle1,
		Cycle2,   // Bus data cycle, stretched by nWait
		Cycle3,
		Cycle4    // Execute of single-cycle ops
	} subCycle_t;

	// Datapath selects
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic [1:0] {NoOverride, AddOverride, SubOverride} aluOr_t;
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1Sel_t;
	typedef enum logic [1:0] {RwRd, RwRa, RwSp} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;

	// Memory bus strobes
	typedef struct packed {
		logic ALE;     // Address latch enable
		logic nME;     // Memory select, active low
		logic nOE;
		logic nWE;
		logic MemEn;
		logic ENB;     // Bus to datapath buffer
		logic IrWe;    // Instruction register load
	} memCtrl_t;

	typedef struct packed {
		logic AluEn;
		logic AluWe;
		op1Sel_t Op1Sel;
		op2Sel_t Op2Sel;
		immSel_t ImmSel;
		aluOr_t AluOr;
	} aluCtrl_t;

	typedef struct packed {
		logic RegWe;
		rs1Sel_t Rs1Sel;
		rwSel_t RwSel;
		wdSel_t WdSel;
	} regCtrl_t;

	typedef struct packed {
		logic PcEn;
		logic PcWe;
		pcSel_t PcSel;
	} pcCtrl_t;

	// Link register
	typedef struct packed {
		logic LrEn;
		logic LrWe;
		lrSel_t LrSel;
	} linkCtrl_t;

	typedef struct packed {
		state_t State;
		subCycle_t SubCycle;
	} seqState_t;

endpackage

/* irqSync.sv */
// Interrupt request synchronizer
`timescale 1ns/10ps

module irqSync #(
	parameter int IrqSyncStages = 2
) (
	input logic Clock,
	input logic nReset,
	input logic nIRQ,
	input logic IntEnable,
	input logic IntDisable,
	output logic IntReq
);

	logic [IrqSyncStages-1:0] irqPipe;   // Bit 0 sees the pin first
	logic intEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqPipe <= '0;
			intEnabled <= 1'b0;
			IntReq <= 1'b0;
		end else begin
			irqPipe <= {irqPipe[IrqSyncStages-2:0], ~nIRQ};
			if (IntDisable) begin   // Entry sequence masks further requests
				intEnabled <= 1'b0;
			end else if (IntEnable) begin
				intEnabled <= 1'b1;
			end
			IntReq <= irqPipe[IrqSyncStages-1] & intEnabled;
		end
	end

endmodule

/* statusFlags.sv */
// Status register and branch conditions
`timescale 1ns/10ps

module statusFlags (
	input logic Clock,
	input logic nReset,
	input logic StatusRegWe,
	input logic [cpuOpcodesPkg::FlagWidth-1:0] Flags,
	input cpuOpcodesPkg::branch_t Branch,
	output logic [cpuOpcodesPkg::FlagWidth-1:0] StatusReg,
	output logic BranchTaken
);

	logic zeroFlag;
	logic signMismatch;   // N xor V, signed less than

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			StatusReg <= '0;
		end else if (StatusRegWe) begin
			StatusReg <= Flags;   // ALU flags of the current op
		end
	end

	assign zeroFlag = StatusReg[cpuOpcodesPkg::FlagZ];
	assign signMismatch = StatusReg[cpuOpcodesPkg::FlagN] ^ StatusReg[cpuOpcodesPkg::FlagV];

	always_comb begin
		case (Branch)
			cpuOpcodesPkg::BR,
			cpuOpcodesPkg::BWL: begin
				BranchTaken = 1'b1;
			end
			cpuOpcodesPkg::BNE: begin
				BranchTaken = ~zeroFlag;
			end
			cpuOpcodesPkg::BE: begin
				BranchTaken = zeroFlag;
			end
			cpuOpcodesPkg::BLT: begin
				BranchTaken = signMismatch;
			end
			cpuOpcodesPkg::BGE: begin
				BranchTaken = ~signMismatch;
			end
			default: begin
				BranchTaken = 1'b0;   // RET and JMP are not conditional
			end
		endcase
	end

endmodule

/* controlSequencer.sv */
// Major state and sub-cycle sequencer
`timescale 1ns/10ps

module controlSequencer (
	input logic Clock,
	input logic nReset,
	input logic nWait,
	input logic IntReq,
	input logic MultiCycle,
	output cpuControlPkg::seqState_t Seq
);

	cpuControlPkg::seqState_t nextSeq;
	cpuControlPkg::seqState_t instrDone;   // Target once an instruction completes
	logic inExecute;

	assign inExecute = (Seq.State == cpuControlPkg::Execute);

	always_comb begin
		instrDone.SubCycle = cpuControlPkg::Cycle0;
		if (IntReq) begin
			instrDone.State = cpuControlPkg::Interrupt;
		end else begin
			instrDone.State = cpuControlPkg::Fetch;
		end
	end

	always_comb begin
		nextSeq = Seq;
		case (Seq.SubCycle)
			cpuControlPkg::Cycle0: nextSeq.SubCycle = cpuControlPkg::Cycle1;
			cpuControlPkg::Cycle1: nextSeq.SubCycle = cpuControlPkg::Cycle2;
			cpuControlPkg::Cycle2: begin
				// Bus cycles hold here, interrupt entry never waits
				if (nWait || Seq.State == cpuControlPkg::Interrupt) begin
					nextSeq.SubCycle = cpuControlPkg::Cycle3;
				end
			end
			cpuControlPkg::Cycle3: begin
				if (Seq.State == cpuControlPkg::Fetch) begin
					nextSeq = '{cpuControlPkg::Execute, cpuControlPkg::Cycle4};
				end else if (inExecute) begin
					nextSeq = instrDone;   // End of LDW or STW
				end else begin
					nextSeq.SubCycle = cpuControlPkg::Cycle4;
				end
			end
			cpuControlPkg::Cycle4: begin
				if (inExecute && MultiCycle) begin
					nextSeq.SubCycle = cpuControlPkg::Cycle0;   // On to the bus access
				end else if (inExecute) begin
					nextSeq = instrDone;
				end else begin
					nextSeq = '{cpuControlPkg::Fetch, cpuControlPkg::Cycle0};
				end
			end
			default: nextSeq = '{cpuControlPkg::Fetch, cpuControlPkg::Cycle0};
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			Seq <= '{cpuControlPkg::Fetch, cpuControlPkg::Cycle0};
		end else begin
			Seq <= nextSeq;
		end
	end

endmodule

/* controlDecoder.sv */
// Control word decoder
`timescale 1ns/10ps

module controlDecoder (
	input cpuControlPkg::seqState_t Seq,
	input cpuOpcodesPkg::opcode_t Opcode,
	input cpuOpcodesPkg::branch_t Branch,
	input logic BranchTaken,
	output cpuControlPkg::memCtrl_t Mem,
	output cpuControlPkg::aluCtrl_t Alu,
	output cpuControlPkg::regCtrl_t Reg,
	output cpuControlPkg::pcCtrl_t Pc,
	output cpuControlPkg::linkCtrl_t Link,
	output logic StatusRegWe,
	output logic IntEnable,
	output logic IntDisable,
	output logic MultiCycle
);

	always_comb begin
		// Idle bus, memory deselected
		Mem = '{ALE: 1'b0, nME: 1'b1, nOE: 1'b0, nWE: 1'b0,
			MemEn: 1'b0, ENB: 1'b0, IrWe: 1'b0};
		Alu = '{AluEn: 1'b0, AluWe: 1'b0, Op1Sel: cpuControlPkg::Op1Rd1,
			Op2Sel: cpuControlPkg::Op2Imm, ImmSel: cpuControlPkg::ImmLong,
			AluOr: cpuControlPkg::NoOverride};
		Reg = '{RegWe: 1'b0, Rs1Sel: cpuControlPkg::Rs1Ra, RwSel: cpuControlPkg::RwRd,
			WdSel: cpuControlPkg::WdAlu};
		Pc = '{PcEn: 1'b0, PcWe: 1'b0, PcSel: cpuControlPkg::Pc1};
		Link = '{LrEn: 1'b0, LrWe: 1'b0, LrSel: cpuControlPkg::LrSys};
		StatusRegWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		MultiCycle = 1'b0;

		case (Seq.State)
			cpuControlPkg::Fetch: begin
				Mem.nWE = 1'b1;
				case (Seq.SubCycle)
					cpuControlPkg::Cycle0: begin
						Mem.ALE = 1'b1;   // PC out as address
						Mem.nOE = 1'b1;
						Pc.PcEn = 1'b1;
					end
					cpuControlPkg::Cycle1: begin
						Mem.nME = 1'b0;
						Mem.nOE = 1'b1;
						Mem.MemEn = 1'b1;
						Pc.PcEn = 1'b1;
					end
					cpuControlPkg::Cycle2: begin
						Mem.nME = 1'b0;
						Mem.MemEn = 1'b1;
						Mem.ENB = 1'b1;
						Mem.IrWe = 1'b1;   // Instruction latched each wait cycle
					end
					cpuControlPkg::Cycle3: Pc.PcEn = 1'b1;
					default: ;
				endcase
			end

			cpuControlPkg::Execute: begin
				case (Seq.SubCycle)
					cpuControlPkg::Cycle4: begin
						// Operand routing
						case (Opcode)
							cpuOpcodesPkg::ADD, cpuOpcodesPkg::SUB, cpuOpcodesPkg::CMP,
							cpuOpcodesPkg::AND, cpuOpcodesPkg::OR, cpuOpcodesPkg::XOR,
							cpuOpcodesPkg::NAND, cpuOpcodesPkg::NOR: begin
								Alu.Op2Sel = cpuControlPkg::Op2Rd2;
							end
							cpuOpcodesPkg::ADDI, cpuOpcodesPkg::SUBI, cpuOpcodesPkg::CMPI,
							cpuOpcodesPkg::LSL, cpuOpcodesPkg::LSR, cpuOpcodesPkg::ASR: begin
								Alu.ImmSel = cpuControlPkg::ImmShort;
							end
							cpuOpcodesPkg::ADDIB, cpuOpcodesPkg::SUBIB: begin
								Reg.Rs1Sel = cpuControlPkg::Rs1Rd;   // Byte immediate into Rd
							end
							default: ;
						endcase

						case (Opcode)
							cpuOpcodesPkg::ADD, cpuOpcodesPkg::ADDI, cpuOpcodesPkg::ADDIB,
							cpuOpcodesPkg::ADC, cpuOpcodesPkg::ADCI, cpuOpcodesPkg::SUB,
							cpuOpcodesPkg::SUBI, cpuOpcodesPkg::SUBIB, cpuOpcodesPkg::SUC,
							cpuOpcodesPkg::SUCI, cpuOpcodesPkg::NEG, cpuOpcodesPkg::AND,
							cpuOpcodesPkg::OR, cpuOpcodesPkg::XOR, cpuOpcodesPkg::NAND,
							cpuOpcodesPkg::NOR, cpuOpcodesPkg::NOT, cpuOpcodesPkg::LSL,
							cpuOpcodesPkg::LSR, cpuOpcodesPkg::ASR: begin
								Pc.PcEn = 1'b1;
								Pc.PcWe = 1'b1;
								Reg.RegWe = 1'b1;
								StatusRegWe = 1'b1;
							end
							cpuOpcodesPkg::CMP, cpuOpcodesPkg::CMPI: begin
								Pc.PcEn = 1'b1;
								Pc.PcWe = 1'b1;
								StatusRegWe = 1'b1;   // Flags only
							end
							cpuOpcodesPkg::LUI, cpuOpcodesPkg::LLI: begin
								Alu.AluEn = 1'b1;
								Reg.Rs1Sel = cpuControlPkg::Rs1Rd;
								Reg.RegWe = 1'b1;
								Pc.PcWe = 1'b1;
							end
							cpuOpcodesPkg::LDW, cpuOpcodesPkg::STW: begin
								Alu.AluEn = 1'b1;   // Address computed ahead of the bus cycle
								Alu.AluWe = 1'b1;
								Alu.ImmSel = cpuControlPkg::ImmShort;
								MultiCycle = 1'b1;
							end
							cpuOpcodesPkg::BRANCH: begin
								Pc.PcWe = 1'b1;
								case (Branch)
									cpuOpcodesPkg::RET: begin
										Link.LrEn = 1'b1;   // Return address via system bus
										Pc.PcSel = cpuControlPkg::PcSysbus;
									end
									cpuOpcodesPkg::JMP: begin
										Alu.ImmSel = cpuControlPkg::ImmShort;
										Pc.PcSel = cpuControlPkg::PcAluOut;
									end
									default: begin
										Alu.AluEn = 1'b1;   // PC relative target
										Alu.Op1Sel = cpuControlPkg::Op1Pc;
										if (BranchTaken) begin
											Pc.PcSel = cpuControlPkg::PcAluOut;
											if (Branch == cpuOpcodesPkg::BWL) begin
												Link.LrWe = 1'b1;
												Link.LrSel = cpuControlPkg::LrPc;
											end
										end
									end
								endcase
							end
							cpuOpcodesPkg::INTCTL: begin
								Pc.PcEn = 1'b1;   // Other codes just step the PC
								Pc.PcWe = 1'b1;
								IntEnable = (Branch == cpuOpcodesPkg::IntEnableCode);
								IntDisable = (Branch == cpuOpcodesPkg::IntDisableCode);
							end
							default: ;
						endcase
					end
					cpuControlPkg::Cycle0: begin
						Mem.ALE = 1'b1;   // Address from ALU register
						Mem.nOE = 1'b1;
						Mem.nWE = 1'b1;
						Alu.AluEn = 1'b1;
						Alu.ImmSel = cpuControlPkg::ImmShort;
					end
					cpuControlPkg::Cycle1: begin
						Mem.nME = 1'b0;
						Mem.nOE = 1'b1;
						Mem.nWE = 1'b1;
						Mem.MemEn = (Opcode == cpuOpcodesPkg::LDW);
						Alu.AluEn = 1'b1;
						Alu.AluWe = 1'b1;   // Rd passes through to the ALU register
						Alu.Op2Sel = cpuControlPkg::Op2Zero;
						Reg.Rs1Sel = cpuControlPkg::Rs1Rd;
					end
					cpuControlPkg::Cycle2: begin
						Mem.nME = 1'b0;
						if (Opcode == cpuOpcodesPkg::LDW) begin
							Mem.nWE = 1'b1;
							Mem.MemEn = 1'b1;
							Mem.ENB = 1'b1;
							Reg.RegWe = 1'b1;   // Load data from the bus
							Reg.WdSel = cpuControlPkg::WdSys;
						end else begin
							Mem.nOE = 1'b1;
							Alu.AluEn = 1'b1;   // Store data on the bus
							Alu.Op2Sel = cpuControlPkg::Op2Zero;
						end
					end
					cpuControlPkg::Cycle3: begin
						Pc.PcWe = 1'b1;   // Single cycle, PC steps once per access
						if (Opcode == cpuOpcodesPkg::LDW) begin
							Mem.nWE = 1'b1;
							Pc.PcEn = 1'b1;
						end else begin
							Mem.nOE = 1'b1;   // nWE low is the write strobe
							Alu.AluEn = 1'b1;
							Alu.Op2Sel = cpuControlPkg::Op2Zero;
						end
					end
					default: ;
				endcase
			end

			cpuControlPkg::Interrupt: begin
				case (Seq.SubCycle)
					cpuControlPkg::Cycle0: begin
						IntDisable = 1'b1;
						Alu.AluEn = 1'b1;   // Decrement SP
						Alu.AluWe = 1'b1;
						Alu.Op2Sel = cpuControlPkg::Op2Zero;
						Alu.AluOr = cpuControlPkg::SubOverride;
						Reg.Rs1Sel = cpuControlPkg::Rs1Sp;
						Reg.RwSel = cpuControlPkg::RwSp;
						Reg.RegWe = 1'b1;
					end
					cpuControlPkg::Cycle1: begin
						Mem.ALE = 1'b1;
						Mem.nOE = 1'b1;
						Mem.nWE = 1'b1;
						Alu.AluEn = 1'b1;
						Alu.Op2Sel = cpuControlPkg::Op2Zero;
						Alu.AluOr = cpuControlPkg::SubOverride;
						Reg.Rs1Sel = cpuControlPkg::Rs1Sp;
					end
					cpuControlPkg::Cycle2: begin
						Mem.nME = 1'b0;
						Mem.nOE = 1'b1;
						Mem.nWE = 1'b1;
						Alu.AluEn = 1'b1;
						Alu.Op2Sel = cpuControlPkg::Op2Zero;
					end
					cpuControlPkg::Cycle3: begin
						Mem.nME = 1'b0;   // Write of the return address
						Mem.nOE = 1'b1;
						Pc.PcEn = 1'b1;
					end
					cpuControlPkg::Cycle4: begin
						Mem.nOE = 1'b1;
						Pc.PcEn = 1'b1;
						Pc.PcWe = 1'b1;
						Pc.PcSel = cpuControlPkg::PcInt;   // Jump to the vector
					end
					default: ;
				endcase
			end

			default: ;
		endcase
	end

endmodule

/* controlUnit.sv */
// Processor control unit
`timescale 1ns/10ps

module controlUnit #(
	parameter int IrqSyncStages = 2
) (
	input logic Clock,
	input logic nReset,
	input logic nIRQ,
	input logic nWait,
	input logic [7:0] OpcodeCondIn,
	input logic [cpuOpcodesPkg::FlagWidth-1:0] Flags,
	output cpuControlPkg::memCtrl_t Mem,
	output cpuControlPkg::aluCtrl_t Alu,
	output cpuControlPkg::regCtrl_t Reg,
	output cpuControlPkg::pcCtrl_t Pc,
	output cpuControlPkg::linkCtrl_t Link,
	output logic [cpuOpcodesPkg::FlagWidth-1:0] StatusReg
);

	cpuOpcodesPkg::opcode_t Opcode;
	cpuOpcodesPkg::branch_t Branch;
	cpuControlPkg::seqState_t Seq;
	logic StatusRegWe;
	logic IntEnable;
	logic IntDisable;
	logic MultiCycle;
	logic BranchTaken;
	logic IntReq;

	// Instruction byte fields
	assign Opcode = cpuOpcodesPkg::opcode_t'(
		OpcodeCondIn[cpuOpcodesPkg::BranchWidth +: cpuOpcodesPkg::OpcodeWidth]);
	assign Branch = cpuOpcodesPkg::branch_t'(OpcodeCondIn[cpuOpcodesPkg::BranchWidth-1:0]);

	irqSync #(
		.IrqSyncStages(IrqSyncStages)
	) irqUnit (
		.Clock(Clock),
		.nReset(nReset),
		.nIRQ(nIRQ),
		.IntEnable(IntEnable),
		.IntDisable(IntDisable),
		.IntReq(IntReq)
	);

	statusFlags statusUnit (
		.Clock(Clock),
		.nReset(nReset),
		.StatusRegWe(StatusRegWe),
		.Flags(Flags),
		.Branch(Branch),
		.StatusReg(StatusReg),
		.BranchTaken(BranchTaken)
	);

	controlSequencer sequencer (
		.Clock(Clock),
		.nReset(nReset),
		.nWait(nWait),
		.IntReq(IntReq),
		.MultiCycle(MultiCycle),
		.Seq(Seq)
	);

	controlDecoder decoder (
		.Seq(Seq),
		.Opcode(Opcode),
		.Branch(Branch),
		.BranchTaken(BranchTaken),
		.Mem(Mem),
		.Alu(Alu),
		.Reg(Reg),
		.Pc(Pc),
		.Link(Link),
		.StatusRegWe(StatusRegWe),
		.IntEnable(IntEnable),
		.IntDisable(IntDisable),
		.MultiCycle(MultiCycle)
	);

endmodule

/* controlUnitModel.svh */
// Control unit reference model
`ifndef CONTROL_UNIT_MODEL_SVH
`define CONTROL_UNIT_MODEL_SVH

// Expected control word plus the model state it belongs to
typedef struct packed {
	cpuControlPkg::state_t state;
	cpuControlPkg::subCycle_t sub;
	cpuControlPkg::memCtrl_t mem;
	cpuControlPkg::aluCtrl_t alu;
	cpuControlPkg::regCtrl_t regs;
	cpuControlPkg::pcCtrl_t pc;
	cpuControlPkg::linkCtrl_t link;
	logic [cpuOpcodesPkg::FlagWidth-1:0] status;
} expectWord_t;

cpuControlPkg::state_t modelState = cpuControlPkg::Fetch;
cpuControlPkg::subCycle_t modelSub = cpuControlPkg::Cycle0;
logic [cpuOpcodesPkg::FlagWidth-1:0] modelStatus = '0;
logic [IrqSyncStages-1:0] modelIrqPipe = '0;
logic modelIntEn = 1'b0;
logic modelIntReq = 1'b0;

// Expected word of the current cycle, then one clock edge of the model
function automatic expectWord_t referenceStep(input logic [7:0] instr,
		input logic [cpuOpcodesPkg::FlagWidth-1:0] flagsIn, input logic nIrqIn,
		input logic nWaitIn);
	expectWord_t w;
	cpuOpcodesPkg::opcode_t op;
	cpuOpcodesPkg::branch_t cond;
	logic taken;
	logic writesFlags;
	logic enableInt;
	logic disableInt;
	logic reqNext;
	op = cpuOpcodesPkg::opcode_t'(instr[7:3]);
	cond = cpuOpcodesPkg::branch_t'(instr[2:0]);
	w = '0;
	w.state = modelState;
	w.sub = modelSub;
	w.status = modelStatus;
	w.mem.nME = 1'b1;
	w.mem.nWE = 1'b1;
	writesFlags = 1'b0;
	enableInt = 1'b0;
	disableInt = 1'b0;
	case (cond)
		cpuOpcodesPkg::BR, cpuOpcodesPkg::BWL: taken = 1'b1;
		cpuOpcodesPkg::BNE: taken = !modelStatus[cpuOpcodesPkg::FlagZ];
		cpuOpcodesPkg::BE: taken = modelStatus[cpuOpcodesPkg::FlagZ];
		cpuOpcodesPkg::BLT: begin
			taken = modelStatus[cpuOpcodesPkg::FlagN] != modelStatus[cpuOpcodesPkg::FlagV];
		end
		cpuOpcodesPkg::BGE: begin
			taken = modelStatus[cpuOpcodesPkg::FlagN] == modelStatus[cpuOpcodesPkg::FlagV];
		end
		default: taken = 1'b0;
	endcase
	if (modelState == cpuControlPkg::Fetch) begin
		w.mem.ALE = (modelSub == cpuControlPkg::Cycle0);
		w.mem.nME = !(modelSub inside {cpuControlPkg::Cycle1, cpuControlPkg::Cycle2});
		w.mem.MemEn = !w.mem.nME;
		w.mem.ENB = (modelSub == cpuControlPkg::Cycle2);
		w.mem.IrWe = (modelSub == cpuControlPkg::Cycle2);
		w.pc.PcEn = (modelSub != cpuControlPkg::Cycle2);
	end else if (modelState == cpuControlPkg::Execute && modelSub == cpuControlPkg::Cycle4) begin
		if (op <= cpuOpcodesPkg::ASR) begin   // ALU group where compares keep Rd
			w.pc.PcWe = 1'b1;
			writesFlags = 1'b1;
			w.regs.RegWe = !(op == cpuOpcodesPkg::CMP || op == cpuOpcodesPkg::CMPI);
		end else if (op == cpuOpcodesPkg::LUI || op == cpuOpcodesPkg::LLI) begin
			w.regs.RegWe = 1'b1;
			w.pc.PcWe = 1'b1;
		end else if (op == cpuOpcodesPkg::LDW || op == cpuOpcodesPkg::STW) begin
			w.alu.AluWe = 1'b1;
		end else if (op == cpuOpcodesPkg::BRANCH) begin
			w.pc.PcWe = 1'b1;
			if (cond == cpuOpcodesPkg::RET) begin
				w.pc.PcSel = cpuControlPkg::PcSysbus;
				w.link.LrEn = 1'b1;
			end else if (cond == cpuOpcodesPkg::JMP || taken) begin
				w.pc.PcSel = cpuControlPkg::PcAluOut;
			end
			if (cond == cpuOpcodesPkg::BWL && taken) begin
				w.link.LrWe = 1'b1;
				w.link.LrSel = cpuControlPkg::LrPc;
			end
		end else if (op == cpuOpcodesPkg::INTCTL) begin
			w.pc.PcWe = 1'b1;
			enableInt = (cond == cpuOpcodesPkg::IntEnableCode);
			disableInt = (cond == cpuOpcodesPkg::IntDisableCode);
		end
	end else if (modelState == cpuControlPkg::Execute) begin   // LDW or STW bus access
		w.mem.ALE = (modelSub == cpuControlPkg::Cycle0);
		w.mem.nME = (modelSub inside {cpuControlPkg::Cycle0, cpuControlPkg::Cycle3});
		w.mem.MemEn = (op == cpuOpcodesPkg::LDW) && !w.mem.nME;
		w.mem.ENB = (op == cpuOpcodesPkg::LDW) && (modelSub == cpuControlPkg::Cycle2);
		w.mem.nWE = (op == cpuOpcodesPkg::LDW) ||
			(modelSub inside {cpuControlPkg::Cycle0, cpuControlPkg::Cycle1});
		w.regs.RegWe = (op == cpuOpcodesPkg::LDW) && (modelSub == cpuControlPkg::Cycle2);
		w.regs.WdSel = w.regs.RegWe ? cpuControlPkg::WdSys : cpuControlPkg::WdAlu;
		w.pc.PcWe = (modelSub == cpuControlPkg::Cycle3);
	end else begin
		disableInt = (modelSub == cpuControlPkg::Cycle0);
		w.pc.PcWe = (modelSub == cpuControlPkg::Cycle4);
		w.pc.PcSel = w.pc.PcWe ? cpuControlPkg::PcInt : cpuControlPkg::Pc1;
	end

	// Clock edge
	if (writesFlags) begin
		modelStatus = flagsIn;
	end
	reqNext = modelIrqPipe[IrqSyncStages-1] & modelIntEn;
	modelIrqPipe = {modelIrqPipe[IrqSyncStages-2:0], ~nIrqIn};
	if (disableInt) begin
		modelIntEn = 1'b0;
	end else if (enableInt) begin
		modelIntEn = 1'b1;
	end
	if (modelState == cpuControlPkg::Execute && (modelSub == cpuControlPkg::Cycle3 ||
			(modelSub == cpuControlPkg::Cycle4 && w.alu.AluWe == 1'b0))) begin
		modelState = modelIntReq ? cpuControlPkg::Interrupt : cpuControlPkg::Fetch;
		modelSub = cpuControlPkg::Cycle0;
	end else if (modelState == cpuControlPkg::Fetch && modelSub == cpuControlPkg::Cycle3) begin
		modelState = cpuControlPkg::Execute;
		modelSub = cpuControlPkg::Cycle4;
	end else if (modelSub == cpuControlPkg::Cycle4) begin
		if (modelState == cpuControlPkg::Interrupt) begin
			modelState = cpuControlPkg::Fetch;
		end
		modelSub = cpuControlPkg::Cycle0;
	end else if (modelSub != cpuControlPkg::Cycle2 || nWaitIn ||
			modelState == cpuControlPkg::Interrupt) begin
		modelSub = cpuControlPkg::subCycle_t'(modelSub + 1);
	end
	modelIntReq = reqNext;
	return w;
endfunction

`endif

/* controlUnit_tb.sv */
// Control unit testbench
`timescale 1ns/10ps

module controlUnit_tb;

	localparam int ClockPeriod = 10;
	localparam int ResetCycles = 8;
	localparam int IrqSyncStages = 2;
	localparam int CyclesPerInstr = 40;   // Generous bound for fetch, waits and entry

	logic Clock;
	logic nReset;
	logic nIRQ;
	logic nWait;
	logic [7:0] OpcodeCondIn;
	logic [cpuOpcodesPkg::FlagWidth-1:0] Flags;
	cpuControlPkg::memCtrl_t Mem;
	cpuControlPkg::aluCtrl_t Alu;
	cpuControlPkg::regCtrl_t Reg;
	cpuControlPkg::pcCtrl_t Pc;
	cpuControlPkg::linkCtrl_t Link;
	logic [cpuOpcodesPkg::FlagWidth-1:0] StatusReg;

	`include "controlUnitModel.svh"

	logic [31:0] lfsrState = 32'h2272a5aa;
	logic [7:0] instrQueue[$];
	logic programReady = 1'b0;
	logic finished = 1'b0;
	int totalInstr = 0;
	int issued = 0;
	int irqLowIndex = 0;   // First instruction issued with nIRQ low
	int waitLeft = 0;
	int pcIntCount = 0;

	controlUnit #(
		.IrqSyncStages(IrqSyncStages)
	) DUT (
		.Clock(Clock),
		.nReset(nReset),
		.nIRQ(nIRQ),
		.nWait(nWait),
		.OpcodeCondIn(OpcodeCondIn),
		.Flags(Flags),
		.Mem(Mem),
		.Alu(Alu),
		.Reg(Reg),
		.Pc(Pc),
		.Link(Link),
		.StatusReg(StatusReg)
	);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003)
				: (lfsrState >> 1);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic compareWord(input expectWord_t w);
		checkValue("StatusReg", w.status, StatusReg);
		checkValue("Pc.PcWe", w.pc.PcWe, Pc.PcWe);
		checkValue("Pc.PcSel", w.pc.PcSel, Pc.PcSel);
		checkValue("Link.LrEn", w.link.LrEn, Link.LrEn);
		checkValue("Link.LrWe", w.link.LrWe, Link.LrWe);
		checkValue("Link.LrSel", w.link.LrSel, Link.LrSel);
		if (w.state != cpuControlPkg::Interrupt) begin
			checkValue("Mem.ALE", w.mem.ALE, Mem.ALE);
			checkValue("Mem.nME", w.mem.nME, Mem.nME);
			checkValue("Mem.MemEn", w.mem.MemEn, Mem.MemEn);
			checkValue("Mem.ENB", w.mem.ENB, Mem.ENB);
			checkValue("Mem.IrWe", w.mem.IrWe, Mem.IrWe);
			checkValue("Reg.RegWe", w.regs.RegWe, Reg.RegWe);
			checkValue("Reg.WdSel", w.regs.WdSel, Reg.WdSel);
			if (w.sub != cpuControlPkg::Cycle4) begin
				checkValue("Mem.nWE", w.mem.nWE, Mem.nWE);   // Bus cycles only
			end else begin
				checkValue("Alu.AluWe", w.alu.AluWe, Alu.AluWe);
			end
		end
		if (w.state == cpuControlPkg::Fetch) begin
			checkValue("Pc.PcEn", w.pc.PcEn, Pc.PcEn);
		end
	endtask

	task automatic buildProgram();
		for (int op = int'(cpuOpcodesPkg::ADD); op <= int'(cpuOpcodesPkg::LLI); op++) begin
			instrQueue.push_back({5'(op), 3'(randomBits(3))});
		end
		// Compare loads random flags ahead of each branch
		for (int rep = 0; rep < 4; rep++) begin
			for (int code = 0; code < 8; code++) begin
				instrQueue.push_back({cpuOpcodesPkg::CMP, 3'(randomBits(3))});
				instrQueue.push_back({cpuOpcodesPkg::BRANCH, 3'(code)});
			end
		end
		for (int i = 0; i < 8; i++) begin
			instrQueue.push_back({i[0] ? cpuOpcodesPkg::STW : cpuOpcodesPkg::LDW,
				3'(randomBits(3))});
		end
		for (int i = 0; i < 24; i++) begin
			instrQueue.push_back({5'(randomBits(5) % 28), 3'(randomBits(3))});
		end
		instrQueue.push_back({cpuOpcodesPkg::INTCTL, cpuOpcodesPkg::IntDisableCode});
		irqLowIndex = instrQueue.size();
		instrQueue.push_back({cpuOpcodesPkg::ADD, 3'd0});
		instrQueue.push_back({cpuOpcodesPkg::SUB, 3'd1});
		instrQueue.push_back({cpuOpcodesPkg::INTCTL, 3'd0});   // No-op code
		instrQueue.push_back({cpuOpcodesPkg::ADD, 3'd2});
		instrQueue.push_back({cpuOpcodesPkg::INTCTL, cpuOpcodesPkg::IntEnableCode});
		instrQueue.push_back({cpuOpcodesPkg::ADD, 3'd3});   // Entry follows this one
		instrQueue.push_back({cpuOpcodesPkg::LDW, 3'd4});
		instrQueue.push_back({cpuOpcodesPkg::ADD, 3'd5});
	endtask

	// Inputs for the cycle the model is now in
	task automatic driveCycle();
		logic [31:0] flagBits;
		flagBits = randomBits(cpuOpcodesPkg::FlagWidth);
		Flags = flagBits[cpuOpcodesPkg::FlagWidth-1:0];
		nWait = 1'b1;
		if (modelState != cpuControlPkg::Interrupt) begin
			if (modelSub == cpuControlPkg::Cycle1) begin
				waitLeft = randomBits(2);
			end else if (modelSub == cpuControlPkg::Cycle2 && waitLeft != 0) begin
				nWait = 1'b0;
				waitLeft--;
			end
		end else if (modelSub == cpuControlPkg::Cycle4) begin
			nIRQ = 1'b1;
		end
		if (modelState == cpuControlPkg::Fetch && modelSub == cpuControlPkg::Cycle0) begin
			if (instrQueue.size() == 0) begin
				finished = 1'b1;
			end else begin
				OpcodeCondIn = instrQueue.pop_front();
				if (issued == irqLowIndex) begin
					nIRQ = 1'b0;
				end
				issued++;
			end
		end
	endtask

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	initial begin
		nReset = 1'b0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		OpcodeCondIn = '0;
		Flags = '0;
		buildProgram();
		totalInstr = instrQueue.size();
		programReady = 1'b1;
		repeat (ResetCycles) @(posedge Clock);
		#1;
		nReset = 1'b1;
		driveCycle();
		while (!finished) begin
			@(posedge Clock);
			#1;
			driveCycle();
		end
		// Only the enabled request enters
		if (pcIntCount == 1) begin
			$display("Simulation completed successfully");
		end else begin
			checkValue("interrupt entries", 1, pcIntCount);
		end
		$finish;
	end

	// Compare at the falling edge, then advance the model
	initial begin
		expectWord_t expected;
		wait (nReset === 1'b1);
		forever begin
			@(negedge Clock);
			expected = referenceStep(OpcodeCondIn, Flags, nIRQ, nWait);
			compareWord(expected);
			if (Pc.PcSel == cpuControlPkg::PcInt) begin
				pcIntCount++;
			end
		end
	end

	initial begin
		wait (programReady);
		#((totalInstr * CyclesPerInstr + ResetCycles) * ClockPeriod);
		$display("Watchdog expired before the instruction sequence finished");
		$display("Simulation failed");
		$fatal(1, "Watchdog timeout");
	end

endmodule

/* controlUnit.f */
+incdir+.
cpuOpcodesPkg.sv
cpuControlPkg.sv
irqSync.sv
statusFlags.sv
controlSequencer.sv
controlDecoder.sv
controlUnit.sv
controlUnit_tb.sv

/* Bender.yml */
package:
  name: controlUnit

sources:
  - cpuOpcodesPkg.sv
  - cpuControlPkg.sv
  - irqSync.sv
  - statusFlags.sv
  - controlSequencer.sv
  - controlDecoder.sv
  - controlUnit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - controlUnit_tb.sv
